// ==== logic/id_params.svh ====
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// ====================
// Datapath sizes

`define ID_DATA_W     32 // Register and operand width
`define ID_REG_ADDR_W 5  // Selects one of ID_NUM_REGS registers
`define ID_NUM_REGS   32

// ====================
// Instruction fields

`define ID_IMM_W      16
`define ID_SHAMT_W    5

`endif

// ==== logic/id_pkg.sv ====
`include "id_params.svh"

package id_pkg;

    // ====================
    // Instruction encodings

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // ====================
    // Execute controls

    typedef enum logic [7:0] {
        ALU_NOP   = 8'h00,
        ALU_SRL   = 8'h02,
        ALU_SRA   = 8'h03,
        ALU_SLLV  = 8'h04,
        ALU_SRLV  = 8'h06,
        ALU_SRAV  = 8'h07,
        ALU_ADD   = 8'h20,
        ALU_ADDU  = 8'h21,
        ALU_SUB   = 8'h22,
        ALU_SUBU  = 8'h23,
        ALU_AND   = 8'h24,
        ALU_OR    = 8'h25, // LUI also uses this
        ALU_XOR   = 8'h26,
        ALU_NOR   = 8'h27,
        ALU_SLT   = 8'h2a,
        ALU_SLTU  = 8'h2b,
        ALU_ADDI  = 8'h55,
        ALU_ADDIU = 8'h56,
        ALU_SLTI  = 8'h57,
        ALU_SLTIU = 8'h58,
        ALU_ANDI  = 8'h59,
        ALU_ORI   = 8'h5a,
        ALU_XORI  = 8'h5b,
        ALU_SLL   = 8'h7c  // Kept apart from NOP, which is all zero
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

    // ====================
    // Instruction word views

    typedef struct packed {
        opcode_e                   opcode;
        logic [`ID_REG_ADDR_W-1:0] rs;
        logic [`ID_REG_ADDR_W-1:0] rt;
        logic [`ID_REG_ADDR_W-1:0] rd;
        logic [`ID_SHAMT_W-1:0]    shamt;
        funct_e                    funct;
    } inst_r_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`ID_REG_ADDR_W-1:0] rs;
        logic [`ID_REG_ADDR_W-1:0] rt;
        logic [`ID_IMM_W-1:0]      imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

    // ====================
    // Stage bundles

    typedef struct packed {
        aluop_e                    aluop;
        alusel_e                   alusel;
        logic                      rd1_en;
        logic                      rd2_en;
        logic [`ID_REG_ADDR_W-1:0] rd1_addr;
        logic [`ID_REG_ADDR_W-1:0] rd2_addr;
        logic [`ID_REG_ADDR_W-1:0] wd;
        logic                      wreg;
        logic [`ID_DATA_W-1:0]     imm;
        logic                      invalid;
    } decode_t;

    typedef struct packed {
        logic                      wreg;
        logic [`ID_REG_ADDR_W-1:0] wd;
        logic [`ID_DATA_W-1:0]     wdata;
    } fwd_t;

    typedef struct packed {
        aluop_e                    aluop;
        alusel_e                   alusel;
        logic [`ID_DATA_W-1:0]     reg1;
        logic [`ID_DATA_W-1:0]     reg2;
        logic [`ID_REG_ADDR_W-1:0] wd;
        logic                      wreg;
    } id_ex_t;

endpackage

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module inst_decoder (
    input  id_pkg::inst_word_u inst_i,
    output id_pkg::decode_t    dec_o
);

    localparam int IMM_PAD   = `ID_DATA_W - `ID_IMM_W;
    localparam int SHAMT_PAD = `ID_DATA_W - `ID_SHAMT_W;

    logic [`ID_DATA_W-1:0] imm_zext;
    logic [`ID_DATA_W-1:0] imm_sext;
    logic [`ID_DATA_W-1:0] imm_upper;
    logic [`ID_DATA_W-1:0] imm_shamt;

    id_pkg::aluop_e        fn_aluop;
    id_pkg::alusel_e       fn_alusel;
    logic                  fn_imm_shift;

    id_pkg::aluop_e        op_aluop;
    id_pkg::alusel_e       op_alusel;
    logic [`ID_DATA_W-1:0] op_imm;

    assign imm_zext  = {{IMM_PAD{1'b0}}, inst_i.i.imm};
    assign imm_sext  = {{IMM_PAD{inst_i.i.imm[`ID_IMM_W-1]}}, inst_i.i.imm};
    assign imm_upper = {inst_i.i.imm, {IMM_PAD{1'b0}}};
    assign imm_shamt = {{SHAMT_PAD{1'b0}}, inst_i.r.shamt};

    // ====================
    // SPECIAL function codes

    assign fn_imm_shift = inst_i.r.funct inside {id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA};

    always_comb begin
        case (inst_i.r.funct)
            id_pkg::FN_OR:   fn_aluop = id_pkg::ALU_OR;
            id_pkg::FN_AND:  fn_aluop = id_pkg::ALU_AND;
            id_pkg::FN_XOR:  fn_aluop = id_pkg::ALU_XOR;
            id_pkg::FN_NOR:  fn_aluop = id_pkg::ALU_NOR;
            id_pkg::FN_SLLV: fn_aluop = id_pkg::ALU_SLLV;
            id_pkg::FN_SRLV: fn_aluop = id_pkg::ALU_SRLV;
            id_pkg::FN_SRAV: fn_aluop = id_pkg::ALU_SRAV;
            id_pkg::FN_SLL:  fn_aluop = id_pkg::ALU_SLL;
            id_pkg::FN_SRL:  fn_aluop = id_pkg::ALU_SRL;
            id_pkg::FN_SRA:  fn_aluop = id_pkg::ALU_SRA;
            id_pkg::FN_ADD:  fn_aluop = id_pkg::ALU_ADD;
            id_pkg::FN_ADDU: fn_aluop = id_pkg::ALU_ADDU;
            id_pkg::FN_SUB:  fn_aluop = id_pkg::ALU_SUB;
            id_pkg::FN_SUBU: fn_aluop = id_pkg::ALU_SUBU;
            id_pkg::FN_SLT:  fn_aluop = id_pkg::ALU_SLT;
            id_pkg::FN_SLTU: fn_aluop = id_pkg::ALU_SLTU;
            default:         fn_aluop = id_pkg::ALU_NOP; // HI/LO, MOVN/MOVZ, MULT, SYNC
        endcase
    end

    always_comb begin
        case (inst_i.r.funct)
            id_pkg::FN_OR, id_pkg::FN_AND, id_pkg::FN_XOR, id_pkg::FN_NOR:
                fn_alusel = id_pkg::SEL_LOGIC;
            id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV,
            id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA:
                fn_alusel = id_pkg::SEL_SHIFT;
            id_pkg::FN_ADD, id_pkg::FN_ADDU, id_pkg::FN_SUB,
            id_pkg::FN_SUBU, id_pkg::FN_SLT, id_pkg::FN_SLTU:
                fn_alusel = id_pkg::SEL_ARITH;
            default:
                fn_alusel = id_pkg::SEL_NOP;
        endcase
    end

    // ====================
    // Major opcodes

    always_comb begin
        case (inst_i.i.opcode)
            id_pkg::OP_ORI:   op_aluop = id_pkg::ALU_ORI;
            id_pkg::OP_ANDI:  op_aluop = id_pkg::ALU_ANDI;
            id_pkg::OP_XORI:  op_aluop = id_pkg::ALU_XORI;
            id_pkg::OP_LUI:   op_aluop = id_pkg::ALU_OR;
            id_pkg::OP_ADDI:  op_aluop = id_pkg::ALU_ADDI;
            id_pkg::OP_ADDIU: op_aluop = id_pkg::ALU_ADDIU;
            id_pkg::OP_SLTI:  op_aluop = id_pkg::ALU_SLTI;
            id_pkg::OP_SLTIU: op_aluop = id_pkg::ALU_SLTIU;
            default:          op_aluop = id_pkg::ALU_NOP; // SPECIAL2, PREF and the rest
        endcase
    end

    always_comb begin
        case (inst_i.i.opcode)
            id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI: begin
                op_alusel = id_pkg::SEL_LOGIC;
                op_imm    = imm_zext;
            end
            id_pkg::OP_LUI: begin
                op_alusel = id_pkg::SEL_LOGIC;
                op_imm    = imm_upper; // ORed with r0 in execute
            end
            id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
                op_alusel = id_pkg::SEL_ARITH;
                op_imm    = imm_sext;
            end
            default: begin
                op_alusel = id_pkg::SEL_NOP;
                op_imm    = '0;
            end
        endcase
    end

    // ====================
    // Control bundle

    always_comb begin
        dec_o.aluop    = id_pkg::ALU_NOP;
        dec_o.alusel   = id_pkg::SEL_NOP;
        dec_o.rd1_en   = 1'b0;
        dec_o.rd2_en   = 1'b0;
        dec_o.rd1_addr = inst_i.r.rs;
        dec_o.rd2_addr = inst_i.r.rt;
        dec_o.wd       = inst_i.r.rd;
        dec_o.wreg     = 1'b0;
        dec_o.imm      = '0;
        dec_o.invalid  = 1'b1;

        if (inst_i.r.opcode == id_pkg::OP_SPECIAL) begin
            if (fn_imm_shift) begin
                if (inst_i.r.rs == '0) begin
                    dec_o.aluop   = fn_aluop;
                    dec_o.alusel  = fn_alusel;
                    dec_o.rd2_en  = 1'b1; // Shift amount takes the first operand slot
                    dec_o.wreg    = 1'b1;
                    dec_o.imm     = imm_shamt;
                    dec_o.invalid = 1'b0;
                end
            end else if (fn_aluop != id_pkg::ALU_NOP && inst_i.r.shamt == '0) begin
                dec_o.aluop   = fn_aluop;
                dec_o.alusel  = fn_alusel;
                dec_o.rd1_en  = 1'b1;
                dec_o.rd2_en  = 1'b1;
                dec_o.wreg    = 1'b1;
                dec_o.invalid = 1'b0;
            end
        end else if (op_aluop != id_pkg::ALU_NOP) begin
            dec_o.aluop   = op_aluop;
            dec_o.alusel  = op_alusel;
            dec_o.rd1_en  = 1'b1;
            dec_o.wd      = inst_i.i.rt;
            dec_o.wreg    = 1'b1;
            dec_o.imm     = op_imm;
            dec_o.invalid = 1'b0;
        end
    end

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module operand_select (
    input  logic                      rd_en_i,
    input  logic [`ID_REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`ID_DATA_W-1:0]     imm_i,
    input  logic [`ID_DATA_W-1:0]     rf_data_i,
    input  id_pkg::fwd_t              ex_fwd_i,
    input  id_pkg::fwd_t              mem_fwd_i,
    output logic [`ID_DATA_W-1:0]     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // Address zero is matched as well
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == rd_addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == rd_addr_i);

    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata; // Youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  id_pkg::fwd_t              wb_i,
    input  logic [`ID_REG_ADDR_W-1:0] rd1_addr_i,
    input  logic [`ID_REG_ADDR_W-1:0] rd2_addr_i,
    output logic [`ID_DATA_W-1:0]     rd1_data_o,
    output logic [`ID_DATA_W-1:0]     rd2_data_o
);

    logic [`ID_DATA_W-1:0] regs [`ID_NUM_REGS];

    // Zero register, then same-cycle writeback, then storage
    function automatic logic [`ID_DATA_W-1:0] read_port(
        input logic [`ID_REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wb_i.wreg && (wb_i.wd == addr)) begin
            return wb_i.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wreg && (wb_i.wd != '0)) begin
            regs[wb_i.wd] <= wb_i.wdata; // r0 stays zero
        end
    end

    always_comb begin
        rd1_data_o = read_port(rd1_addr_i);
        rd2_data_o = read_port(rd2_addr_i);
    end

endmodule

// ==== logic/id_ex_reg.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_ex_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  id_pkg::decode_t       dec_i,
    input  logic [`ID_DATA_W-1:0] reg1_i,
    input  logic [`ID_DATA_W-1:0] reg2_i,
    output id_pkg::id_ex_t        ex_o,
    output logic                  invalid_o
);

    id_pkg::id_ex_t ex_d;

    always_comb begin
        ex_d.aluop  = dec_i.aluop;
        ex_d.alusel = dec_i.alusel;
        ex_d.reg1   = reg1_i;
        ex_d.reg2   = reg2_i;
        ex_d.wd     = dec_i.wd;
        ex_d.wreg   = dec_i.wreg;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_o.aluop  <= id_pkg::ALU_NOP; // Execute sees a bubble
            ex_o.alusel <= id_pkg::SEL_NOP;
            ex_o.reg1   <= '0;
            ex_o.reg2   <= '0;
            ex_o.wd     <= '0;
            ex_o.wreg   <= 1'b0;
            invalid_o   <= 1'b0;
        end else begin
            ex_o      <= ex_d;
            invalid_o <= dec_i.invalid;
        end
    end

endmodule

// ==== logic/id_stage_top.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_stage_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  id_pkg::inst_word_u inst_i,
    input  id_pkg::fwd_t       ex_fwd_i,
    input  id_pkg::fwd_t       mem_fwd_i,
    input  id_pkg::fwd_t       wb_i,
    output id_pkg::id_ex_t     ex_o,
    output logic               invalid_o
);

    id_pkg::decode_t       dec;
    logic [`ID_DATA_W-1:0] rf_rd1_data;
    logic [`ID_DATA_W-1:0] rf_rd2_data;
    logic [`ID_DATA_W-1:0] op1;
    logic [`ID_DATA_W-1:0] op2;

    // ====================
    // Decode and read

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_i       (wb_i),
        .rd1_addr_i (dec.rd1_addr),
        .rd2_addr_i (dec.rd2_addr),
        .rd1_data_o (rf_rd1_data),
        .rd2_data_o (rf_rd2_data)
    );

    // ====================
    // Operands

    operand_select u_op1 (
        .rd_en_i   (dec.rd1_en),
        .rd_addr_i (dec.rd1_addr),
        .imm_i     (dec.imm),
        .rf_data_i (rf_rd1_data),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op1)
    );

    operand_select u_op2 (
        .rd_en_i   (dec.rd2_en),
        .rd_addr_i (dec.rd2_addr),
        .imm_i     (dec.imm),
        .rf_data_i (rf_rd2_data),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op2)
    );

    id_ex_reg u_id_ex_reg (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .dec_i     (dec),
        .reg1_i    (op1),
        .reg2_i    (op2),
        .ex_o      (ex_o),
        .invalid_o (invalid_o)
    );

endmodule

// ==== tests/id_stage_checker.sv ====
`timescale 1ns/1ns

module id_stage_checker (
    input logic           clk,
    input logic           rst_n_i,
    input id_pkg::id_ex_t ex_i,
    input logic           invalid_i
);

    int unsigned fail_count = 0;

    // ====================
    // Output rules

    reset_gives_bubble: assert property (@(posedge clk) !rst_n_i |=> (!ex_i.wreg && !invalid_i))
        else begin
            fail_count++;
            $error("Stage output not cleared one cycle after reset");
        end

    invalid_is_nop: assert property (@(posedge clk) disable iff (!rst_n_i)
        invalid_i |-> (!ex_i.wreg && ex_i.aluop == id_pkg::ALU_NOP))
        else begin
            fail_count++;
            $error("Reserved instruction left a write or an ALU operation");
        end

endmodule

bind id_stage_top id_stage_checker u_checker (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .ex_i      (ex_o),
    .invalid_i (invalid_o)
);

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/1ns
`include "id_params.svh"

module id_stage_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 75;
    localparam int RANDOM_CYCLES   = 200;
    localparam int MARGIN_CYCLES   = 50;
    localparam int TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    localparam id_pkg::fwd_t IDLE_FWD = '0;

    localparam logic [5:0] R_FUNCTS [16] = '{
        id_pkg::FN_OR, id_pkg::FN_AND, id_pkg::FN_XOR, id_pkg::FN_NOR,
        id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV,
        id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA,
        id_pkg::FN_ADD, id_pkg::FN_ADDU, id_pkg::FN_SUB,
        id_pkg::FN_SUBU, id_pkg::FN_SLT, id_pkg::FN_SLTU
    };

    localparam logic [5:0] I_OPCODES [8] = '{
        id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI, id_pkg::OP_LUI,
        id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU
    };

    logic                  clk;
    logic                  rst_n;
    logic [`ID_DATA_W-1:0] inst;
    id_pkg::fwd_t          ex_fwd;
    id_pkg::fwd_t          mem_fwd;
    id_pkg::fwd_t          wb;
    id_pkg::id_ex_t        ex_out;
    logic                  invalid;
    logic [`ID_DATA_W-1:0] reg_model [`ID_NUM_REGS];

    id_stage_top DUT (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .inst_i    (inst),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .wb_i      (wb),
        .ex_o      (ex_out),
        .invalid_o (invalid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error at %0t ns: the tests did not finish before the watchdog expired", $time);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        wait (DUT.u_checker.fail_count != 0);
        $display("Error at %0t ns: a bound assertion on the stage outputs failed", $time);
        $display("Done: errors found");
        $fatal(1, "Checker assertion failed");
    end

    // ====================
    // Reference model

    function automatic logic [31:0] make_r(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] make_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_pkg::fwd_t make_fwd(input logic wreg, input logic [4:0] wd,
                                              input logic [31:0] wdata);
        id_pkg::fwd_t b;
        b.wreg  = wreg;
        b.wd    = wd;
        b.wdata = wdata;
        return b;
    endfunction

    // EX before MEM before the register file, which passes a same-cycle write through
    function automatic logic [31:0] read_operand(input logic [4:0] addr);
        if (ex_fwd.wreg && ex_fwd.wd == addr) return ex_fwd.wdata;
        if (mem_fwd.wreg && mem_fwd.wd == addr) return mem_fwd.wdata;
        if (addr == 5'd0) return '0;
        if (wb.wreg && wb.wd == addr) return wb.wdata;
        return reg_model[addr];
    endfunction

    function automatic id_pkg::aluop_e funct_aluop(input logic [5:0] fn);
        case (fn)
            id_pkg::FN_OR:   return id_pkg::ALU_OR;
            id_pkg::FN_AND:  return id_pkg::ALU_AND;
            id_pkg::FN_XOR:  return id_pkg::ALU_XOR;
            id_pkg::FN_NOR:  return id_pkg::ALU_NOR;
            id_pkg::FN_SLLV: return id_pkg::ALU_SLLV;
            id_pkg::FN_SRLV: return id_pkg::ALU_SRLV;
            id_pkg::FN_SRAV: return id_pkg::ALU_SRAV;
            id_pkg::FN_SLL:  return id_pkg::ALU_SLL;
            id_pkg::FN_SRL:  return id_pkg::ALU_SRL;
            id_pkg::FN_SRA:  return id_pkg::ALU_SRA;
            id_pkg::FN_ADD:  return id_pkg::ALU_ADD;
            id_pkg::FN_ADDU: return id_pkg::ALU_ADDU;
            id_pkg::FN_SUB:  return id_pkg::ALU_SUB;
            id_pkg::FN_SUBU: return id_pkg::ALU_SUBU;
            id_pkg::FN_SLT:  return id_pkg::ALU_SLT;
            id_pkg::FN_SLTU: return id_pkg::ALU_SLTU;
            default:         return id_pkg::ALU_NOP;
        endcase
    endfunction

    function automatic id_pkg::aluop_e opcode_aluop(input logic [5:0] op);
        case (op)
            id_pkg::OP_ORI:   return id_pkg::ALU_ORI;
            id_pkg::OP_ANDI:  return id_pkg::ALU_ANDI;
            id_pkg::OP_XORI:  return id_pkg::ALU_XORI;
            id_pkg::OP_LUI:   return id_pkg::ALU_OR;
            id_pkg::OP_ADDI:  return id_pkg::ALU_ADDI;
            id_pkg::OP_ADDIU: return id_pkg::ALU_ADDIU;
            id_pkg::OP_SLTI:  return id_pkg::ALU_SLTI;
            id_pkg::OP_SLTIU: return id_pkg::ALU_SLTIU;
            default:          return id_pkg::ALU_NOP;
        endcase
    endfunction

    function automatic void expect_decode(input logic [31:0] w, output id_pkg::id_ex_t exp,
                                          output logic bad);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        logic        logic_fn;
        logic        arith_fn;
        op         = w[31:26];
        fn         = w[5:0];
        imm        = w[15:0];
        exp.aluop  = id_pkg::ALU_NOP;
        exp.alusel = id_pkg::SEL_NOP;
        exp.reg1   = '0;
        exp.reg2   = '0;
        exp.wd     = w[15:11];
        exp.wreg   = 1'b1;
        if (op == id_pkg::OP_SPECIAL) begin
            logic_fn  = fn inside {id_pkg::FN_OR, id_pkg::FN_AND, id_pkg::FN_XOR, id_pkg::FN_NOR};
            arith_fn  = fn inside {id_pkg::FN_ADD, id_pkg::FN_ADDU, id_pkg::FN_SUB,
                                   id_pkg::FN_SUBU, id_pkg::FN_SLT, id_pkg::FN_SLTU};
            exp.aluop = funct_aluop(fn);
            exp.alusel = logic_fn ? id_pkg::SEL_LOGIC
                                  : (arith_fn ? id_pkg::SEL_ARITH : id_pkg::SEL_SHIFT);
            exp.reg2  = read_operand(w[20:16]);
            if (fn inside {id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA}) begin
                bad      = (w[25:21] != 5'd0);
                exp.reg1 = {27'd0, w[10:6]}; // Zero-extended shift amount
            end else begin
                bad      = (exp.aluop == id_pkg::ALU_NOP) || (w[10:6] != 5'd0);
                exp.reg1 = read_operand(w[25:21]);
            end
        end else begin
            exp.aluop  = opcode_aluop(op);
            bad        = (exp.aluop == id_pkg::ALU_NOP);
            exp.alusel = (op inside {id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI,
                                     id_pkg::OP_SLTIU}) ? id_pkg::SEL_ARITH : id_pkg::SEL_LOGIC;
            exp.wd     = w[20:16];
            exp.reg1   = read_operand(w[25:21]);
            if (op == id_pkg::OP_LUI) begin
                exp.reg2 = {imm, 16'h0000};
            end else if (op inside {id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI}) begin
                exp.reg2 = {16'h0000, imm};
            end else begin
                exp.reg2 = {{16{imm[15]}}, imm};
            end
        end
    endfunction

    // ====================
    // Drive and check

    task automatic report_mismatch(input string what, input logic [31:0] w,
                                   input id_pkg::id_ex_t got, input id_pkg::id_ex_t exp);
        $display("Error at %0t ns: %s, inst %h gave %h invalid %b, expected %h",
                 $time, what, w, got, invalid, exp);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    // Called on a falling edge, returns on the next one
    task automatic run_cycle(input logic [31:0] w, input id_pkg::fwd_t ex_b,
                             input id_pkg::fwd_t mem_b, input id_pkg::fwd_t wb_b);
        id_pkg::id_ex_t exp;
        logic           exp_bad;
        inst    = w;
        ex_fwd  = ex_b;
        mem_fwd = mem_b;
        wb      = wb_b;
        expect_decode(w, exp, exp_bad);
        @(posedge clk);
        if (wb_b.wreg && wb_b.wd != 5'd0) reg_model[wb_b.wd] = wb_b.wdata;
        @(negedge clk);
        if (exp_bad) begin
            assert (invalid && !ex_out.wreg && ex_out.aluop == id_pkg::ALU_NOP
                    && ex_out.alusel == id_pkg::SEL_NOP)
                else report_mismatch("reserved encoding not turned into a NOP", w, ex_out, exp);
        end else begin
            assert (!invalid && ex_out == exp)
                else report_mismatch("decode result differs", w, ex_out, exp);
        end
    endtask

    function automatic id_pkg::fwd_t random_bundle();
        return make_fwd(1'($urandom_range(1)), 5'($urandom_range(7)), $urandom());
    endfunction

    // ====================
    // Tests

    task automatic test_reset();
        id_pkg::id_ex_t nop;
        nop        = '0;
        nop.aluop  = id_pkg::ALU_NOP;
        nop.alusel = id_pkg::SEL_NOP;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (ex_out == nop && invalid == 1'b0)
            else report_mismatch("stage output after reset", inst, ex_out, nop);
        rst_n = 1'b1;
    endtask

    task automatic test_r_type();
        for (int r = 1; r < `ID_NUM_REGS; r++) begin
            run_cycle('0, IDLE_FWD, IDLE_FWD, make_fwd(1'b1, 5'(r), 32'h9E37_79B9 * (r + 1)));
        end
        for (int k = 0; k < 16; k++) begin
            if (R_FUNCTS[k] inside {id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA}) begin
                run_cycle(make_r(5'd0, 5'd12, 5'd3, 5'd9, R_FUNCTS[k]),
                          IDLE_FWD, IDLE_FWD, IDLE_FWD);
            end else begin
                run_cycle(make_r(5'd17, 5'd12, 5'd3, 5'd0, R_FUNCTS[k]),
                          IDLE_FWD, IDLE_FWD, IDLE_FWD);
            end
        end
    endtask

    task automatic test_i_type();
        for (int k = 0; k < 8; k++) begin
            run_cycle(make_i(I_OPCODES[k], 5'd21, 5'd4, 16'h8F3C), IDLE_FWD, IDLE_FWD, IDLE_FWD);
            run_cycle(make_i(I_OPCODES[k], 5'd0, 5'd8, 16'h1234), IDLE_FWD, IDLE_FWD, IDLE_FWD);
        end
    endtask

    task automatic test_forwarding();
        logic [31:0] add_5_6;
        add_5_6 = make_r(5'd5, 5'd6, 5'd3, 5'd0, id_pkg::FN_ADD);
        run_cycle(add_5_6, make_fwd(1'b1, 5'd5, 32'hAAAA_0001), make_fwd(1'b1, 5'd5, 32'hBBBB_0002),
                  IDLE_FWD);
        run_cycle(add_5_6, make_fwd(1'b1, 5'd6, 32'hCCCC_0003), make_fwd(1'b1, 5'd5, 32'hDDDD_0004),
                  IDLE_FWD);
        run_cycle(add_5_6, make_fwd(1'b1, 5'd7, 32'hEEEE_0005), make_fwd(1'b0, 5'd5, 32'hFFFF_0006),
                  IDLE_FWD);
        run_cycle(make_r(5'd9, 5'd9, 5'd10, 5'd0, id_pkg::FN_OR), IDLE_FWD, IDLE_FWD,
                  make_fwd(1'b1, 5'd9, 32'h1357_9BDF));
        run_cycle(make_r(5'd0, 5'd0, 5'd11, 5'd0, id_pkg::FN_ADD), IDLE_FWD, IDLE_FWD,
                  make_fwd(1'b1, 5'd0, 32'h2468_ACE0));
    endtask

    task automatic test_dropped();
        run_cycle(make_r(5'd1, 5'd2, 5'd0, 5'd0, 6'b011000), IDLE_FWD, IDLE_FWD, IDLE_FWD); // MULT
        run_cycle(make_r(5'd0, 5'd0, 5'd3, 5'd0, 6'b010000), IDLE_FWD, IDLE_FWD, IDLE_FWD); // MFHI
        run_cycle(make_r(5'd1, 5'd2, 5'd3, 5'd0, 6'b001011), IDLE_FWD, IDLE_FWD, IDLE_FWD); // MOVN
        run_cycle({6'b011100, 5'd1, 5'd3, 5'd3, 5'd0, 6'b100000}, IDLE_FWD, IDLE_FWD, IDLE_FWD);
        run_cycle(make_r(5'd1, 5'd2, 5'd3, 5'd4, id_pkg::FN_ADD), IDLE_FWD, IDLE_FWD, IDLE_FWD);
        run_cycle(make_r(5'd1, 5'd2, 5'd3, 5'd4, id_pkg::FN_SLL), IDLE_FWD, IDLE_FWD, IDLE_FWD);
    endtask

    task automatic test_random();
        logic [31:0] w;
        int unsigned pick;
        repeat (RANDOM_CYCLES) begin
            pick = $urandom_range(23);
            if (pick < 16) begin
                w = make_r(5'($urandom_range(7)), 5'($urandom_range(7)), 5'($urandom),
                           5'd0, R_FUNCTS[pick]);
                if (R_FUNCTS[pick] inside {id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA}) begin
                    w[25:21] = 5'd0;
                    w[10:6]  = 5'($urandom);
                end
            end else begin
                w = make_i(I_OPCODES[pick - 16], 5'($urandom_range(7)), 5'($urandom_range(7)),
                           16'($urandom));
            end
            run_cycle(w, random_bundle(), random_bundle(), random_bundle());
        end
    endtask

    initial begin
        void'($urandom(80));
        rst_n   = 1'b0;
        inst    = '0;
        ex_fwd  = IDLE_FWD;
        mem_fwd = IDLE_FWD;
        wb      = IDLE_FWD;
        foreach (reg_model[i]) reg_model[i] = '0;
        test_reset();
        test_r_type();
        test_i_type();
        test_forwarding();
        test_dropped();
        test_random();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/id_pkg.sv
logic/inst_decoder.sv
logic/operand_select.sv
logic/reg_file.sv
logic/id_ex_reg.sv
logic/id_stage_top.sv
tests/id_stage_checker.sv
tests/id_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module id_stage_tb -f sources.f -o id_stage_sim

./obj_dir/id_stage_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
